// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
TOP       := tb_top
RTL_TOP   := de0_nano_db25_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: board_ctrl_pkg.sv
/*
  Shared definitions for the board housekeeping logic:
  port widths, default timing constants,
  reset channel indices and the vector and event word types
*/

`default_nettype none

package board_ctrl_pkg;

  // ============================
  // widths
  // ============================
  localparam int unsigned KEY_COUNT      = 2;         // push keys
  localparam int unsigned SW_COUNT       = 4;         // slide switches
  localparam int unsigned LED_PIO_COUNT  = 7;         // processor driven leds
  localparam int unsigned RST_CHANNELS   = 3;         // cold, warm, debug
  localparam int unsigned HW_EVENT_WIDTH = 28;        // stm event word

  // channel order inside every reset vector
  localparam int unsigned RST_COLD  = 0;
  localparam int unsigned RST_WARM  = 1;
  localparam int unsigned RST_DEBUG = 2;

  // ============================
  // default timing, 50 MHz cycles
  // ============================
  localparam int unsigned DEF_DEBOUNCE_TIMEOUT = 50000;     // 1 ms
  localparam int unsigned DEF_HEARTBEAT_HALF   = 25000000;  // 0.5 s per led level
  localparam int unsigned DEF_PULSE_LEN_COLD   = 6;
  localparam int unsigned DEF_PULSE_LEN_WARM   = 2;
  localparam int unsigned DEF_PULSE_LEN_DEBUG  = 32;

  typedef logic [KEY_COUNT-1:0]     key_t;
  typedef logic [SW_COUNT-1:0]      sw_t;
  typedef logic [LED_PIO_COUNT-1:0] led_pio_t;
  typedef logic [RST_CHANNELS-1:0]  rst_vec_t;

  // event word, msb first
  typedef struct packed {
    logic [HW_EVENT_WIDTH-SW_COUNT-LED_PIO_COUNT-KEY_COUNT-1:0] pad;  // always zero
    sw_t      sw;                                     // switch levels
    led_pio_t led_pio;                                // processor led levels
    key_t     key;                                    // debounced keys, low = pressed
  } hw_event_t;

endpackage

`default_nettype wire

// File: board_ctrl_testdata.txt
// columns in hex: key sw led_pio hps_reset_req hold
// key is active low, hold counts clock cycles, a hold of 0 ends the list
3 0 00 0 0a   // idle after reset
3 a 55 0 04   // switches and processor leds
3 5 2a 0 04
2 5 2a 0 08   // key0 glitch shorter than the timeout
3 5 2a 0 14
1 5 2a 0 0a   // key1 glitch
3 5 2a 0 14
2 5 2a 0 28   // key0 pressed and held
0 5 2a 0 28   // both keys pressed
3 5 2a 0 28   // both released
3 5 2a 1 04   // cold request
3 5 2a 0 10
3 5 2a 2 04   // warm request
3 5 2a 0 0c
3 5 2a 4 04   // debug request
3 5 2a 0 06
3 5 2a 4 04   // second debug edge inside the pulse
3 5 2a 0 30
3 5 2a 7 03   // all three at once
3 5 2a 0 2a
3 f 7f 1 01   // one cycle cold request
3 0 00 0 02
3 0 00 1 01   // cold edge while busy
3 0 00 0 14
1 9 41 2 02   // warm request with a key1 glitch
3 9 41 0 50   // run on for the heartbeat
0 0 00 0 00

// File: build.f
board_ctrl_pkg.sv
key_debounce.sv
reset_req_sync.sv
reset_pulse_stretch.sv
f2h_port_reg.sv
heartbeat.sv
de0_nano_db25_top.sv
tb_checker.sv
tb_top.sv

// File: de0_nano_db25_top.sv
/*
  Board housekeeping top level
  key debouncer, reset request sync and three pulse stretchers,
  fabric to HPS output registers and heartbeat LED
*/

`timescale 1ns/1ns
`default_nettype none

module de0_nano_db25_top
  import board_ctrl_pkg::*;
#(
  parameter int unsigned DEBOUNCE_TIMEOUT = DEF_DEBOUNCE_TIMEOUT,
  parameter int unsigned HEARTBEAT_HALF   = DEF_HEARTBEAT_HALF,
  parameter int unsigned PULSE_LEN_COLD   = DEF_PULSE_LEN_COLD,
  parameter int unsigned PULSE_LEN_WARM   = DEF_PULSE_LEN_WARM,
  parameter int unsigned PULSE_LEN_DEBUG  = DEF_PULSE_LEN_DEBUG
) (
  input  logic                      fpga_clk_50,
  input  logic                      hps_fpga_reset_n,
  input  logic [KEY_COUNT-1:0]      key,              // push keys, low = pressed
  input  logic [SW_COUNT-1:0]       sw,
  input  logic [LED_PIO_COUNT-1:0]  led_pio,          // from the processor
  input  logic [RST_CHANNELS-1:0]   hps_reset_req,    // cold, warm, debug
  output logic [LED_PIO_COUNT:0]    led,
  output logic                      cold_reset_req_n,
  output logic                      warm_reset_req_n,
  output logic                      debug_reset_req_n,
  output logic [HW_EVENT_WIDTH-1:0] stm_hw_events
);

  key_t     key_clean;                                // debounced keys
  rst_vec_t rst_trigger;                              // edge pulses per channel
  rst_vec_t rst_pulse;                                // stretched pulses
  logic     led_beat;

  key_debounce #(
    .DEBOUNCE_TIMEOUT (DEBOUNCE_TIMEOUT)
  ) key_debounce_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .key_clean        (key_clean)
  );

  // ============================
  // reset request path
  // ============================
  reset_req_sync reset_req_sync_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .hps_reset_req    (hps_reset_req),
    .rst_trigger      (rst_trigger)
  );

  for (genvar ch = 0; ch < RST_CHANNELS; ch++)
  begin : g_rst_ch
    // length picked by channel index
    localparam int unsigned LEN = (ch == RST_COLD) ? PULSE_LEN_COLD :
                                  (ch == RST_WARM) ? PULSE_LEN_WARM : PULSE_LEN_DEBUG;

    reset_pulse_stretch #(
      .PULSE_LEN        (LEN)
    ) reset_pulse_stretch_inst (
      .fpga_clk_50      (fpga_clk_50),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .trigger          (rst_trigger[ch]),
      .pulse            (rst_pulse[ch])
    );
  end

  f2h_port_reg f2h_port_reg_inst (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .rst_pulse         (rst_pulse),
    .sw                (sw),
    .led_pio           (led_pio),
    .key_clean         (key_clean),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .stm_hw_events     (stm_hw_events)
  );

  heartbeat #(
    .HEARTBEAT_HALF   (HEARTBEAT_HALF)
  ) heartbeat_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_beat         (led_beat)
  );

  assign led = {led_pio, led_beat};                   // led[0] is the heartbeat

endmodule

`default_nettype wire

// File: f2h_port_reg.sv
/*
  Fabric to HPS output register stage
  active low cold, warm and debug reset requests
  registered 28 bit hardware event word
*/

`timescale 1ns/1ns
`default_nettype none

module f2h_port_reg
  import board_ctrl_pkg::*;
(
  input  logic      fpga_clk_50,
  input  logic      hps_fpga_reset_n,
  input  rst_vec_t  rst_pulse,                        // high active stretched pulses
  input  sw_t       sw,
  input  led_pio_t  led_pio,
  input  key_t      key_clean,
  output logic      cold_reset_req_n,
  output logic      warm_reset_req_n,
  output logic      debug_reset_req_n,
  output hw_event_t stm_hw_events
);

  hw_event_t event_next;                              // word before the register

  always_comb
  begin
    event_next         = '0;                          // pad bits stay zero
    event_next.sw      = sw;
    event_next.led_pio = led_pio;
    event_next.key     = key_clean;
  end

  // ============================
  // output registers
  // ============================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cold_reset_req_n  <= 1'b1;                      // no request
      warm_reset_req_n  <= 1'b1;
      debug_reset_req_n <= 1'b1;
      stm_hw_events     <= '0;
    end
    else
    begin
      cold_reset_req_n  <= ~rst_pulse[RST_COLD];
      warm_reset_req_n  <= ~rst_pulse[RST_WARM];
      debug_reset_req_n <= ~rst_pulse[RST_DEBUG];
      stm_hw_events     <= event_next;
    end
  end

endmodule

`default_nettype wire

// File: heartbeat.sv
/*
  Heartbeat LED
  half period counter, led level toggles on each wrap
*/

`timescale 1ns/1ns
`default_nettype none

module heartbeat
  import board_ctrl_pkg::*;
#(
  parameter int unsigned HEARTBEAT_HALF = DEF_HEARTBEAT_HALF
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led_beat                               // blinking level
);

  localparam int unsigned CNT_W = $clog2(HEARTBEAT_HALF + 1);
  localparam logic [CNT_W-1:0] CNT_WRAP = CNT_W'(HEARTBEAT_HALF - 1);

  logic [CNT_W-1:0] half_cnt;                         // cycles into the half period

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      half_cnt <= '0;
      led_beat <= 1'b0;                               // led off after reset
    end
    else if (half_cnt == CNT_WRAP)
    begin
      half_cnt <= '0;
      led_beat <= ~led_beat;                          // half period done
    end
    else
      half_cnt <= half_cnt + 1'b1;
  end

  a_cnt_range: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    half_cnt < CNT_W'(HEARTBEAT_HALF));

endmodule

`default_nettype wire

// File: key_debounce.sv
/*
  Push key debouncer
  two flop input synchronizer
  one stability counter per key, output flips after a stable timeout
*/

`timescale 1ns/1ns
`default_nettype none

module key_debounce
  import board_ctrl_pkg::*;
#(
  parameter int unsigned DEBOUNCE_TIMEOUT = DEF_DEBOUNCE_TIMEOUT
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  key_t key,                                   // raw keys, active low
  output key_t key_clean                              // debounced keys
);

  localparam int unsigned CNT_W = $clog2(DEBOUNCE_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_TIMEOUT - 1);

  key_t             key_meta;                         // first sync stage
  key_t             key_sync;                         // second sync stage
  logic [CNT_W-1:0] stable_cnt [KEY_COUNT];           // cycles of disagreement

  // ============================
  // input synchronizer
  // ============================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;                                 // released
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ============================
  // stability counters
  // ============================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_clean <= '1;                                // keys released after reset
      for (int i = 0; i < KEY_COUNT; i++)
      begin
        stable_cnt[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < KEY_COUNT; i++)
      begin
        if (key_sync[i] == key_clean[i])
          stable_cnt[i] <= '0;                        // agree, restart
        else if (stable_cnt[i] == CNT_LAST)
        begin
          key_clean[i]  <= key_sync[i];               // held long enough
          stable_cnt[i] <= '0;
        end
        else
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
      end
    end
  end

  // a key may only flip on the cycle its count reaches the timeout
  for (genvar g = 0; g < KEY_COUNT; g++)
  begin : g_key_chk
    a_key_hold: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      $changed(key_clean[g]) |-> ($past(stable_cnt[g]) == CNT_LAST));
  end

endmodule

`default_nettype wire

// File: reset_pulse_stretch.sv
/*
  Reset pulse stretcher for one channel
  down counter loaded by a trigger when idle,
  pulse high while the count is nonzero
*/

`timescale 1ns/1ns
`default_nettype none

module reset_pulse_stretch
  import board_ctrl_pkg::*;
#(
  parameter int unsigned PULSE_LEN = DEF_PULSE_LEN_COLD
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic trigger,                               // one cycle request
  output logic pulse                                  // active high, PULSE_LEN cycles
);

  localparam int unsigned CNT_W = $clog2(PULSE_LEN + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PULSE_LEN);

  logic [CNT_W-1:0] remain;                           // cycles of pulse left

  // ============================
  // pulse counter
  // ============================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      remain <= '0;
    else if (remain != '0)
      remain <= remain - 1'b1;                        // busy, trigger dropped
    else if (trigger)
      remain <= CNT_LOAD;                             // idle, start a pulse
  end

  assign pulse = (remain != '0);

  // once started, the pulse is gone after exactly PULSE_LEN cycles
  a_pulse_len: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $rose(pulse) |-> ##PULSE_LEN !pulse);

endmodule

`default_nettype wire

// File: reset_req_sync.sv
/*
  Reset request synchronizer
  two stage sync of the three request levels,
  short history of the synced level and a registered rising edge trigger
*/

`timescale 1ns/1ns
`default_nettype none

module reset_req_sync
  import board_ctrl_pkg::*;
(
  input  logic     fpga_clk_50,
  input  logic     hps_fpga_reset_n,
  input  rst_vec_t hps_reset_req,                     // request levels, async
  output rst_vec_t rst_trigger                        // one cycle per rising edge
);

  rst_vec_t req_meta;                                 // first sync stage
  rst_vec_t req_sync;                                 // second sync stage
  rst_vec_t req_d;                                    // delayed copy of req_sync
  rst_vec_t req_dd;                                   // one more cycle back

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_meta    <= '0;
      req_sync    <= '0;
      req_d       <= '0;
      req_dd      <= '0;
      rst_trigger <= '0;
    end
    else
    begin
      req_meta    <= hps_reset_req;
      req_sync    <= req_meta;
      req_d       <= req_sync;
      req_dd      <= req_d;
      rst_trigger <= req_d & ~req_dd;                 // low to high per channel
    end
  end

  // a trigger never holds for two cycles, even on a chattering request
  for (genvar g = 0; g < RST_CHANNELS; g++)
  begin : g_trig_chk
    a_trig_single: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      rst_trigger[g] |=> !rst_trigger[g]);
  end

endmodule

`default_nettype wire

// File: tb_checker.sv
/*
  Testbench monitor for the board housekeeping top level
  reference models of debounce, request pulses, event word and heartbeat
  per cycle compare at the falling clock edge, error counters
*/

`timescale 1ns/1ns
`default_nettype none

module tb_checker
  import board_ctrl_pkg::*;
#(
  parameter int unsigned DEBOUNCE_TIMEOUT = DEF_DEBOUNCE_TIMEOUT,
  parameter int unsigned HEARTBEAT_HALF   = DEF_HEARTBEAT_HALF,
  parameter int unsigned PULSE_LEN_COLD   = DEF_PULSE_LEN_COLD,
  parameter int unsigned PULSE_LEN_WARM   = DEF_PULSE_LEN_WARM,
  parameter int unsigned PULSE_LEN_DEBUG  = DEF_PULSE_LEN_DEBUG
) (
  input  logic                      fpga_clk_50,
  input  logic                      hps_fpga_reset_n,
  input  key_t                      key,
  input  sw_t                       sw,
  input  led_pio_t                  led_pio,
  input  rst_vec_t                  hps_reset_req,
  input  logic [LED_PIO_COUNT:0]    led,
  input  logic                      cold_reset_req_n,
  input  logic                      warm_reset_req_n,
  input  logic                      debug_reset_req_n,
  input  logic [HW_EVENT_WIDTH-1:0] stm_hw_events,
  output int                        req_errors,
  output int                        event_errors,
  output int                        led_errors,
  output rst_vec_t                  pulse_seen
);

  int          req_err   = 0;
  int          event_err = 0;
  int          led_err   = 0;
  rst_vec_t    seen      = '0;
  logic        rst_seen  = 1'b0;                        // reset level one falling edge back
  int unsigned cycle;                                   // rising edges since reset release
  key_t        in_key;                                  // inputs the next edge samples
  sw_t         in_sw;
  led_pio_t    in_led;
  rst_vec_t    in_req;
  key_t        key_hist1;                               // key sampled one edge back
  key_t        key_hist2;                               // two edges back, leaves the sync
  key_t        clean;                                   // expected debounced level
  int unsigned run [KEY_COUNT];                         // edges of disagreement
  rst_vec_t    req_last;                                // request level at previous edge
  int unsigned win_start [RST_CHANNELS];                // first edge with the pin low
  int unsigned win_end [RST_CHANNELS];                  // last edge with the pin low
  int unsigned free_at [RST_CHANNELS];                  // first edge a new pulse may load
  hw_event_t   exp_event;

  assign req_errors   = req_err;
  assign event_errors = event_err;
  assign led_errors   = led_err;
  assign pulse_seen   = seen;

  function automatic int unsigned pulse_len(input int ch);
    if (ch == RST_COLD)
      return PULSE_LEN_COLD;
    else if (ch == RST_WARM)
      return PULSE_LEN_WARM;
    return PULSE_LEN_DEBUG;
  endfunction

  function automatic string req_name(input int ch);
    if (ch == RST_COLD)
      return "cold_reset_req_n";
    else if (ch == RST_WARM)
      return "warm_reset_req_n";
    return "debug_reset_req_n";
  endfunction

  task automatic clear_model();
    cycle     = 0;
    key_hist1 = '1;                                     // sync flops come out of reset high
    key_hist2 = '1;
    clean     = '1;
    req_last  = '0;
    exp_event = '0;
    for (int k = 0; k < KEY_COUNT; k++)
      run[k] = 0;
    for (int ch = 0; ch < RST_CHANNELS; ch++)
    begin
      win_start[ch] = 1;                                // empty window
      win_end[ch]   = 0;
      free_at[ch]   = 0;
    end
  endtask

  // ==============================
  // one rising edge of the model
  // ==============================
  task automatic advance_model();
    cycle++;
    exp_event         = '0;                             // keys one edge behind the debouncer
    exp_event.sw      = in_sw;
    exp_event.led_pio = in_led;
    exp_event.key     = clean;
    for (int k = 0; k < KEY_COUNT; k++)
    begin
      if (key_hist2[k] != clean[k])
      begin
        run[k]++;
        if (run[k] == DEBOUNCE_TIMEOUT)
        begin
          clean[k] = key_hist2[k];                      // stable long enough
          run[k]   = 0;
        end
      end
      else
        run[k] = 0;
    end
    key_hist2 = key_hist1;
    key_hist1 = in_key;
    // rising edge shows on the pin 5 edges later, ignored while the channel is busy
    for (int ch = 0; ch < RST_CHANNELS; ch++)
    begin
      if (in_req[ch] && !req_last[ch] && (cycle + 4 >= free_at[ch]))
      begin
        win_start[ch] = cycle + 5;
        win_end[ch]   = cycle + 4 + pulse_len(ch);
        free_at[ch]   = cycle + 5 + pulse_len(ch);
      end
    end
    req_last = in_req;
  endtask

  task automatic check_outputs();
    rst_vec_t req_got;
    rst_vec_t req_exp;
    logic     beat_exp;
    req_got  = {debug_reset_req_n, warm_reset_req_n, cold_reset_req_n};
    beat_exp = ((cycle / HEARTBEAT_HALF) % 2) != 0;     // flips every half period
    for (int ch = 0; ch < RST_CHANNELS; ch++)
    begin
      req_exp[ch] = !(cycle >= win_start[ch] && cycle <= win_end[ch]);
      if (req_got[ch] !== req_exp[ch])
      begin
        $display("[ERROR] %0t ns %s exp=%h got=%h", $time, req_name(ch),
                 req_exp[ch], req_got[ch]);
        req_err++;
      end
      if (req_got[ch] === 1'b0)
        seen[ch] = 1'b1;
    end
    if (stm_hw_events !== exp_event)
    begin
      $display("[ERROR] %0t ns stm_hw_events exp=%h got=%h", $time, exp_event, stm_hw_events);
      event_err++;
    end
    if (led[0] !== beat_exp)
    begin
      $display("[ERROR] %0t ns led[0] exp=%h got=%h", $time, beat_exp, led[0]);
      led_err++;
    end
    if (led[LED_PIO_COUNT:1] !== led_pio)
    begin
      $display("[ERROR] %0t ns led[7:1] exp=%h got=%h", $time, led_pio, led[LED_PIO_COUNT:1]);
      led_err++;
    end
  endtask

  // mid cycle, outputs and driven inputs are both settled here
  always @(negedge fpga_clk_50)
  begin
    if (!hps_fpga_reset_n)
      clear_model();
    else if (rst_seen)
      advance_model();                                  // an edge passed out of reset
    check_outputs();
    in_key   = key;
    in_sw    = sw;
    in_led   = led_pio;
    in_req   = hps_reset_req;
    rst_seen = hps_fpga_reset_n;
  end

endmodule

`default_nettype wire

// File: tb_top.sv
/*
  Testbench top for the board housekeeping logic
  clock, reset, stimulus records from the data file,
  watchdog and the closing error report
*/

`timescale 1ns/1ns
`default_nettype none

module tb_top
  import board_ctrl_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned DRIVE_DELAY  = 2;             // after the rising edge
  localparam int unsigned RESET_CYCLES = 2;
  localparam int unsigned TB_DEBOUNCE  = 16;
  localparam int unsigned TB_HEARTBEAT = 40;
  localparam int unsigned MAX_RECORDS  = 64;
  localparam int unsigned REC_WORDS    = 5;             // key, sw, led_pio, request, hold
  localparam int unsigned WATCH_MARGIN = 20;            // cycles past the stimulus

  logic                      fpga_clk_50      = 1'b0;
  logic                      hps_fpga_reset_n = 1'b1;   // pulled low just after time zero
  key_t                      key              = '1;     // released
  sw_t                       sw               = '0;
  led_pio_t                  led_pio          = '0;
  rst_vec_t                  hps_reset_req    = '0;
  logic [LED_PIO_COUNT:0]    led;
  logic                      cold_reset_req_n;
  logic                      warm_reset_req_n;
  logic                      debug_reset_req_n;
  logic [HW_EVENT_WIDTH-1:0] stm_hw_events;

  logic [31:0] stim_mem [MAX_RECORDS*REC_WORDS];        // raw words from the data file
  int unsigned record_count = 0;
  int unsigned total_hold   = 0;                        // cycles of stimulus in the file
  logic        watch_armed  = 1'b0;
  int          other_errors = 0;
  int          req_errors;
  int          event_errors;
  int          led_errors;
  rst_vec_t    pulse_seen;                              // request pin seen low per channel

  de0_nano_db25_top #(
    .DEBOUNCE_TIMEOUT  (TB_DEBOUNCE),
    .HEARTBEAT_HALF    (TB_HEARTBEAT)
  ) de0_nano_db25_top_i (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led_pio           (led_pio),
    .hps_reset_req     (hps_reset_req),
    .led               (led),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .stm_hw_events     (stm_hw_events)
  );

  tb_checker #(
    .DEBOUNCE_TIMEOUT  (TB_DEBOUNCE),
    .HEARTBEAT_HALF    (TB_HEARTBEAT)
  ) checker_i (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led_pio           (led_pio),
    .hps_reset_req     (hps_reset_req),
    .led               (led),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .stm_hw_events     (stm_hw_events),
    .req_errors        (req_errors),
    .event_errors      (event_errors),
    .led_errors        (led_errors),
    .pulse_seen        (pulse_seen)
  );

  // ==============================
  // clock and watchdog
  // ==============================
  initial
  begin
    forever #(CLK_PERIOD/2) fpga_clk_50 = ~fpga_clk_50;
  end

  initial
  begin
    int unsigned limit_ns;
    wait (watch_armed);
    limit_ns = (RESET_CYCLES + total_hold + WATCH_MARGIN) * CLK_PERIOD;
    #(limit_ns);
    $display("run timed out after %0d ns, the stimulus never finished", limit_ns);
    $display("errors: request=%0d event=%0d led=%0d other=%0d",
             req_errors, event_errors, led_errors, other_errors + 1);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic load_records();
    for (int i = 0; i < MAX_RECORDS*REC_WORDS; i++)
      stim_mem[i] = '0;
    $readmemh("board_ctrl_testdata.txt", stim_mem);
    // a hold of zero closes the list
    while (record_count < MAX_RECORDS && stim_mem[record_count*REC_WORDS + 4] != 0)
    begin
      total_hold += stim_mem[record_count*REC_WORDS + 4];
      record_count++;
    end
  endtask

  task automatic apply_record(input int unsigned idx, output int unsigned hold);
    int unsigned base;
    base          = idx * REC_WORDS;
    key           = stim_mem[base][KEY_COUNT-1:0];
    sw            = stim_mem[base+1][SW_COUNT-1:0];
    led_pio       = stim_mem[base+2][LED_PIO_COUNT-1:0];
    hps_reset_req = stim_mem[base+3][RST_CHANNELS-1:0];
    hold          = stim_mem[base+4];
  endtask

  // ==============================
  // stimulus and report
  // ==============================
  initial
  begin
    int unsigned hold;
    load_records();
    if (record_count == 0)
    begin
      $display("no stimulus records were read from board_ctrl_testdata.txt");
      other_errors++;
    end
    watch_armed = 1'b1;
    #(DRIVE_DELAY);
    hps_fpga_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge fpga_clk_50);
    #(DRIVE_DELAY);
    hps_fpga_reset_n = 1'b1;
    for (int unsigned i = 0; i < record_count; i++)
    begin
      apply_record(i, hold);
      repeat (hold) @(posedge fpga_clk_50);
      #(DRIVE_DELAY);
    end
    repeat (4) @(posedge fpga_clk_50);                  // last compares
    for (int ch = 0; ch < RST_CHANNELS; ch++)
    begin
      if (!pulse_seen[ch])
      begin
        $display("reset channel %0d never drove its request output low", ch);
        other_errors++;
      end
    end
    $display("errors: request=%0d event=%0d led=%0d other=%0d",
             req_errors, event_errors, led_errors, other_errors);
    if (req_errors + event_errors + led_errors + other_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
